/* manycore_settings.svh */
// pod grid size, word and address widths, memory depths and request FIFO depth
`ifndef MANYCORE_SETTINGS_SVH
`define MANYCORE_SETTINGS_SVH

// compute tile grid, vcache rows sit above and below it
`define MC_NUM_TILES_X 2
`define MC_NUM_TILES_Y 2

// endpoints: all tiles plus a north and south vcache per column
`define MC_NUM_EPS (`MC_NUM_TILES_X * (`MC_NUM_TILES_Y + 2))

`define MC_DATA_WIDTH 32
`define MC_ADDR_WIDTH 8

// words per endpoint memory
`define MC_DMEM_WORDS 64
`define MC_VCACHE_WORDS 256

// host request buffering
`define MC_FWD_FIFO_ELS 4

`endif

/* manycore_pkt_pkg.sv */
// request packet field types and request op encoding
`include "manycore_settings.svh"

package manycore_pkt_pkg;

  // destination column and row
  // row 0 north vcache, rows 1..Y tiles, row Y+1 south vcache
  typedef logic [1:0] x_cord_t;
  typedef logic [1:0] y_cord_t;

  typedef logic [`MC_DATA_WIDTH-1:0] data_t;

  // word address inside one endpoint
  typedef logic [`MC_ADDR_WIDTH-1:0] addr_t;

  // one bit per byte lane
  typedef logic [`MC_DATA_WIDTH/8-1:0] mask_t;

  typedef enum logic [1:0] {
    op_load,
    op_store,
    op_amo_add
  } op_e;

endpackage

/* manycore_ctrl_pkg.sv */
// endpoint index type and crossbar controller states
`include "manycore_settings.svh"

package manycore_ctrl_pkg;

  // tiles first in row-major order, then north vcaches, then south vcaches
  typedef logic [$clog2(`MC_NUM_EPS)-1:0] ep_idx_t;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait,
    st_resp
  } ctrl_state_e;

endpackage

/* manycore_fwd_fifo.sv */
// circular request FIFO with valid/ready-and enqueue and valid/yumi dequeue
`timescale 1ns/1ps
`include "manycore_settings.svh"

module manycore_fwd_fifo #(
  parameter int els_p = `MC_FWD_FIFO_ELS
) (
  input clk_i
  , input reset_i

  , input enq_v_i
  , output logic enq_ready_o
  , input manycore_pkt_pkg::op_e enq_op_i
  , input manycore_pkt_pkg::x_cord_t enq_x_i
  , input manycore_pkt_pkg::y_cord_t enq_y_i
  , input manycore_pkt_pkg::addr_t enq_addr_i
  , input manycore_pkt_pkg::data_t enq_data_i
  , input manycore_pkt_pkg::mask_t enq_mask_i

  , output logic deq_v_o
  , input deq_yumi_i
  , output manycore_pkt_pkg::op_e deq_op_o
  , output manycore_pkt_pkg::x_cord_t deq_x_o
  , output manycore_pkt_pkg::y_cord_t deq_y_o
  , output manycore_pkt_pkg::addr_t deq_addr_o
  , output manycore_pkt_pkg::data_t deq_data_o
  , output manycore_pkt_pkg::mask_t deq_mask_o
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  manycore_pkt_pkg::op_e op_mem [els_p];
  manycore_pkt_pkg::x_cord_t x_mem [els_p];
  manycore_pkt_pkg::y_cord_t y_mem [els_p];
  manycore_pkt_pkg::addr_t addr_mem [els_p];
  manycore_pkt_pkg::data_t data_mem [els_p];
  manycore_pkt_pkg::mask_t mask_mem [els_p];

  logic [ptr_w_lp-1:0] rptr_r, wptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic enq, deq;

  // a full FIFO still takes a request when the head leaves this cycle
  assign enq_ready_o = (count_r != cnt_w_lp'(els_p)) || deq_yumi_i;
  assign deq_v_o = (count_r != '0);
  assign enq = enq_v_i && enq_ready_o;
  assign deq = deq_yumi_i && deq_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r <= '0;
      wptr_r <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (deq) begin
        rptr_r <= (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(enq) - cnt_w_lp'(deq);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      op_mem[wptr_r] <= enq_op_i;
      x_mem[wptr_r] <= enq_x_i;
      y_mem[wptr_r] <= enq_y_i;
      addr_mem[wptr_r] <= enq_addr_i;
      data_mem[wptr_r] <= enq_data_i;
      mask_mem[wptr_r] <= enq_mask_i;
    end
  end

  assign deq_op_o = op_mem[rptr_r];
  assign deq_x_o = x_mem[rptr_r];
  assign deq_y_o = y_mem[rptr_r];
  assign deq_addr_o = addr_mem[rptr_r];
  assign deq_data_o = data_mem[rptr_r];
  assign deq_mask_o = mask_mem[rptr_r];

endmodule

/* manycore_xbar_ctrl.sv */
// crossbar controller: coordinate decode, endpoint strobe, response capture and hold
`timescale 1ns/1ps
`include "manycore_settings.svh"

module manycore_xbar_ctrl (
  input clk_i
  , input reset_i

  , input deq_v_i
  , output logic deq_yumi_o
  , input manycore_pkt_pkg::op_e deq_op_i
  , input manycore_pkt_pkg::x_cord_t deq_x_i
  , input manycore_pkt_pkg::y_cord_t deq_y_i
  , input manycore_pkt_pkg::addr_t deq_addr_i
  , input manycore_pkt_pkg::data_t deq_data_i
  , input manycore_pkt_pkg::mask_t deq_mask_i

  , output logic [`MC_NUM_EPS-1:0] ep_v_o
  , output manycore_pkt_pkg::op_e ep_op_o
  , output manycore_pkt_pkg::addr_t ep_addr_o
  , output manycore_pkt_pkg::data_t ep_data_o
  , output manycore_pkt_pkg::mask_t ep_mask_o
  , input [`MC_NUM_EPS-1:0] ep_rsp_v_i
  , input manycore_pkt_pkg::data_t [`MC_NUM_EPS-1:0] ep_rsp_data_i
  , input [`MC_NUM_EPS-1:0] ep_rsp_err_i

  , output logic host_rsp_v_o
  , input host_rsp_ready_i
  , output manycore_pkt_pkg::data_t host_rsp_data_o
  , output logic host_rsp_err_o
);

  localparam int num_tiles_lp = `MC_NUM_TILES_X * `MC_NUM_TILES_Y;

  manycore_ctrl_pkg::ctrl_state_e state_r, state_n;
  manycore_ctrl_pkg::ep_idx_t head_idx, idx_r;
  logic head_bad;

  // decode the head coordinate to a flat endpoint index
  always_comb begin
    int x_int;
    int y_int;
    x_int = int'(deq_x_i);
    y_int = int'(deq_y_i);
    head_bad = 1'b0;
    head_idx = '0;
    if (x_int >= `MC_NUM_TILES_X) begin
      head_bad = 1'b1;
    end else if (y_int == 0) begin
      head_idx = manycore_ctrl_pkg::ep_idx_t'(num_tiles_lp + x_int);
    end else if (y_int <= `MC_NUM_TILES_Y) begin
      head_idx = manycore_ctrl_pkg::ep_idx_t'((y_int - 1) * `MC_NUM_TILES_X + x_int);
    end else if (y_int == `MC_NUM_TILES_Y + 1) begin
      head_idx = manycore_ctrl_pkg::ep_idx_t'(num_tiles_lp + `MC_NUM_TILES_X + x_int);
    end else begin
      head_bad = 1'b1;
    end
  end

  assign deq_yumi_o = (state_r == manycore_ctrl_pkg::st_idle) && deq_v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      manycore_ctrl_pkg::st_idle: begin
        if (deq_v_i) begin
          // unreachable endpoints answer right away
          state_n = head_bad ? manycore_ctrl_pkg::st_resp : manycore_ctrl_pkg::st_issue;
        end
      end
      manycore_ctrl_pkg::st_issue: state_n = manycore_ctrl_pkg::st_wait;
      manycore_ctrl_pkg::st_wait: begin
        if (ep_rsp_v_i[idx_r]) begin
          state_n = manycore_ctrl_pkg::st_resp;
        end
      end
      manycore_ctrl_pkg::st_resp: begin
        if (host_rsp_ready_i) begin
          state_n = manycore_ctrl_pkg::st_idle;
        end
      end
      default: state_n = manycore_ctrl_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= manycore_ctrl_pkg::st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // request fields held while in flight, response held for the host
  always_ff @(posedge clk_i) begin
    if (deq_yumi_o) begin
      idx_r <= head_idx;
      ep_op_o <= deq_op_i;
      ep_addr_o <= deq_addr_i;
      ep_data_o <= deq_data_i;
      ep_mask_o <= deq_mask_i;
    end
    if (deq_yumi_o && head_bad) begin
      host_rsp_data_o <= '0;
      host_rsp_err_o <= 1'b1;
    end else if (state_r == manycore_ctrl_pkg::st_wait && ep_rsp_v_i[idx_r]) begin
      host_rsp_data_o <= ep_rsp_data_i[idx_r];
      host_rsp_err_o <= ep_rsp_err_i[idx_r];
    end
  end

  always_comb begin
    ep_v_o = '0;
    if (state_r == manycore_ctrl_pkg::st_issue) begin
      ep_v_o[idx_r] = 1'b1;
    end
  end

  assign host_rsp_v_o = (state_r == manycore_ctrl_pkg::st_resp);

endmodule

/* manycore_tile_dmem.sv */
// compute tile data memory with load, store and atomic add
`timescale 1ns/1ps
`include "manycore_settings.svh"

module manycore_tile_dmem (
  input clk_i
  , input reset_i
  , input v_i
  , input manycore_pkt_pkg::op_e op_i
  , input manycore_pkt_pkg::addr_t addr_i
  , input manycore_pkt_pkg::data_t data_i
  , output logic rsp_v_o
  , output manycore_pkt_pkg::data_t rsp_data_o
  , output logic rsp_err_o
);

  localparam int idx_w_lp = $clog2(`MC_DMEM_WORDS);

  manycore_pkt_pkg::data_t mem_r [`MC_DMEM_WORDS];
  logic [idx_w_lp-1:0] idx;
  manycore_pkt_pkg::data_t rd_data;

  assign idx = idx_w_lp'(addr_i % `MC_DMEM_WORDS);
  assign rd_data = mem_r[idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_o <= 1'b0;
      rsp_err_o <= 1'b0;
    end else begin
      rsp_v_o <= v_i;
      rsp_err_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      case (op_i)
        manycore_pkt_pkg::op_store: begin
          mem_r[idx] <= data_i;
          rsp_data_o <= '0;
        end
        // atomic add returns the old word
        manycore_pkt_pkg::op_amo_add: begin
          mem_r[idx] <= rd_data + data_i;
          rsp_data_o <= rd_data;
        end
        default: rsp_data_o <= rd_data;
      endcase
    end
  end

endmodule

/* manycore_vcache_bank.sv */
// vcache backing memory with load, byte-masked store and atomic refusal
`timescale 1ns/1ps
`include "manycore_settings.svh"

module manycore_vcache_bank (
  input clk_i
  , input reset_i
  , input v_i
  , input manycore_pkt_pkg::op_e op_i
  , input manycore_pkt_pkg::addr_t addr_i
  , input manycore_pkt_pkg::data_t data_i
  , input manycore_pkt_pkg::mask_t mask_i
  , output logic rsp_v_o
  , output manycore_pkt_pkg::data_t rsp_data_o
  , output logic rsp_err_o
);

  localparam int idx_w_lp = $clog2(`MC_VCACHE_WORDS);
  localparam int mask_w_lp = $bits(manycore_pkt_pkg::mask_t);

  manycore_pkt_pkg::data_t mem_r [`MC_VCACHE_WORDS];
  logic [idx_w_lp-1:0] idx;
  manycore_pkt_pkg::data_t rd_data;
  manycore_pkt_pkg::data_t wr_data;

  assign idx = idx_w_lp'(addr_i % `MC_VCACHE_WORDS);
  assign rd_data = mem_r[idx];

  // merge enabled byte lanes into the old word
  always_comb begin
    wr_data = rd_data;
    for (int b = 0; b < mask_w_lp; b++) begin
      if (mask_i[b]) begin
        wr_data[8*b +: 8] = data_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_o <= 1'b0;
      rsp_err_o <= 1'b0;
    end else begin
      rsp_v_o <= v_i;
      rsp_err_o <= v_i && (op_i == manycore_pkt_pkg::op_amo_add);
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      case (op_i)
        manycore_pkt_pkg::op_store: begin
          mem_r[idx] <= wr_data;
          rsp_data_o <= '0;
        end
        // no atomics here, memory untouched
        manycore_pkt_pkg::op_amo_add: rsp_data_o <= '0;
        default: rsp_data_o <= rd_data;
      endcase
    end
  end

endmodule

/* manycore_pod_xbar.sv */
// pod top: request FIFO, crossbar controller, compute tiles and vcache banks
`timescale 1ns/1ps
`include "manycore_settings.svh"

module manycore_pod_xbar (
  input clk_i
  , input reset_i

  , input host_req_v_i
  , output logic host_req_ready_o
  , input manycore_pkt_pkg::op_e host_req_op_i
  , input manycore_pkt_pkg::x_cord_t host_req_x_i
  , input manycore_pkt_pkg::y_cord_t host_req_y_i
  , input manycore_pkt_pkg::addr_t host_req_addr_i
  , input manycore_pkt_pkg::data_t host_req_data_i
  , input manycore_pkt_pkg::mask_t host_req_mask_i

  , output logic host_rsp_v_o
  , input host_rsp_ready_i
  , output manycore_pkt_pkg::data_t host_rsp_data_o
  , output logic host_rsp_err_o
);

  localparam int num_tiles_lp = `MC_NUM_TILES_X * `MC_NUM_TILES_Y;

  logic deq_v, deq_yumi;
  manycore_pkt_pkg::op_e deq_op;
  manycore_pkt_pkg::x_cord_t deq_x;
  manycore_pkt_pkg::y_cord_t deq_y;
  manycore_pkt_pkg::addr_t deq_addr;
  manycore_pkt_pkg::data_t deq_data;
  manycore_pkt_pkg::mask_t deq_mask;

  logic [`MC_NUM_EPS-1:0] ep_v;
  manycore_pkt_pkg::op_e ep_op;
  manycore_pkt_pkg::addr_t ep_addr;
  manycore_pkt_pkg::data_t ep_data;
  manycore_pkt_pkg::mask_t ep_mask;
  logic [`MC_NUM_EPS-1:0] ep_rsp_v;
  manycore_pkt_pkg::data_t [`MC_NUM_EPS-1:0] ep_rsp_data;
  logic [`MC_NUM_EPS-1:0] ep_rsp_err;

  manycore_fwd_fifo #(
    .els_p(`MC_FWD_FIFO_ELS)
  ) fwd_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.enq_v_i(host_req_v_i)
    ,.enq_ready_o(host_req_ready_o)
    ,.enq_op_i(host_req_op_i)
    ,.enq_x_i(host_req_x_i)
    ,.enq_y_i(host_req_y_i)
    ,.enq_addr_i(host_req_addr_i)
    ,.enq_data_i(host_req_data_i)
    ,.enq_mask_i(host_req_mask_i)
    ,.deq_v_o(deq_v)
    ,.deq_yumi_i(deq_yumi)
    ,.deq_op_o(deq_op)
    ,.deq_x_o(deq_x)
    ,.deq_y_o(deq_y)
    ,.deq_addr_o(deq_addr)
    ,.deq_data_o(deq_data)
    ,.deq_mask_o(deq_mask)
  );

  manycore_xbar_ctrl xbar_ctrl (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.deq_v_i(deq_v)
    ,.deq_yumi_o(deq_yumi)
    ,.deq_op_i(deq_op)
    ,.deq_x_i(deq_x)
    ,.deq_y_i(deq_y)
    ,.deq_addr_i(deq_addr)
    ,.deq_data_i(deq_data)
    ,.deq_mask_i(deq_mask)
    ,.ep_v_o(ep_v)
    ,.ep_op_o(ep_op)
    ,.ep_addr_o(ep_addr)
    ,.ep_data_o(ep_data)
    ,.ep_mask_o(ep_mask)
    ,.ep_rsp_v_i(ep_rsp_v)
    ,.ep_rsp_data_i(ep_rsp_data)
    ,.ep_rsp_err_i(ep_rsp_err)
    ,.host_rsp_v_o(host_rsp_v_o)
    ,.host_rsp_ready_i(host_rsp_ready_i)
    ,.host_rsp_data_o(host_rsp_data_o)
    ,.host_rsp_err_o(host_rsp_err_o)
  );

  // compute tiles, row-major from the north
  for (genvar r = 0; r < `MC_NUM_TILES_Y; r++) begin : g_tile_y
    for (genvar c = 0; c < `MC_NUM_TILES_X; c++) begin : g_tile_x
      manycore_tile_dmem tile (
        .clk_i(clk_i)
        ,.reset_i(reset_i)
        ,.v_i(ep_v[r*`MC_NUM_TILES_X+c])
        ,.op_i(ep_op)
        ,.addr_i(ep_addr)
        ,.data_i(ep_data)
        ,.rsp_v_o(ep_rsp_v[r*`MC_NUM_TILES_X+c])
        ,.rsp_data_o(ep_rsp_data[r*`MC_NUM_TILES_X+c])
        ,.rsp_err_o()
      );
      // tiles never refuse a request
      assign ep_rsp_err[r*`MC_NUM_TILES_X+c] = 1'b0;
    end
  end

  // north and south vcache per column
  for (genvar c = 0; c < `MC_NUM_TILES_X; c++) begin : g_vc
    manycore_vcache_bank north_vc (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.v_i(ep_v[num_tiles_lp+c])
      ,.op_i(ep_op)
      ,.addr_i(ep_addr)
      ,.data_i(ep_data)
      ,.mask_i(ep_mask)
      ,.rsp_v_o(ep_rsp_v[num_tiles_lp+c])
      ,.rsp_data_o(ep_rsp_data[num_tiles_lp+c])
      ,.rsp_err_o(ep_rsp_err[num_tiles_lp+c])
    );

    manycore_vcache_bank south_vc (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.v_i(ep_v[num_tiles_lp+`MC_NUM_TILES_X+c])
      ,.op_i(ep_op)
      ,.addr_i(ep_addr)
      ,.data_i(ep_data)
      ,.mask_i(ep_mask)
      ,.rsp_v_o(ep_rsp_v[num_tiles_lp+`MC_NUM_TILES_X+c])
      ,.rsp_data_o(ep_rsp_data[num_tiles_lp+`MC_NUM_TILES_X+c])
      ,.rsp_err_o(ep_rsp_err[num_tiles_lp+`MC_NUM_TILES_X+c])
    );
  end

endmodule

/* manycore_pod_assertions.sv */
// bound checks on the pod host response link and the endpoint strobes
`timescale 1ns/1ps
`include "manycore_settings.svh"

module manycore_pod_assertions (
  input clk_i
  , input reset_i
  , input host_rsp_v_i
  , input host_rsp_ready_i
  , input manycore_pkt_pkg::data_t host_rsp_data_i
  , input host_rsp_err_i
  , input [`MC_NUM_EPS-1:0] ep_v_i
  , input [`MC_NUM_EPS-1:0] ep_rsp_v_i
);

  // payload holds while the host stalls
  rsp_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    host_rsp_v_i && !host_rsp_ready_i |=>
      host_rsp_v_i && $stable(host_rsp_data_i) && $stable(host_rsp_err_i)
  ) else $error("host response changed while the host stalled");

  // one endpoint strobed at a time and only that endpoint answers a cycle later
  strobe_onehot: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(ep_v_i) && (ep_rsp_v_i == $past(ep_v_i))
  ) else $error("endpoint strobes not one-hot or answered by the wrong endpoint");

  rsp_quiet_in_reset: assert property (
    @(posedge clk_i) reset_i |=> !host_rsp_v_i
  ) else $error("host response valid during reset");

endmodule

bind manycore_pod_xbar manycore_pod_assertions pod_checks (
  .clk_i(clk_i)
  ,.reset_i(reset_i)
  ,.host_rsp_v_i(host_rsp_v_o)
  ,.host_rsp_ready_i(host_rsp_ready_i)
  ,.host_rsp_data_i(host_rsp_data_o)
  ,.host_rsp_err_i(host_rsp_err_o)
  ,.ep_v_i(ep_v)
  ,.ep_rsp_v_i(ep_rsp_v)
);

/* tb_manycore_pod_xbar.sv */
// testbench for the pod crossbar: file-driven requests, random host stalls, in-order checks
`timescale 1ns/1ps

module tb_manycore_pod_xbar;

  localparam int max_vecs_lp = 64;
  localparam int clk_period_lp = 20;

  logic clk_i;
  logic reset_i;
  logic host_req_v_i;
  logic host_req_ready_o;
  manycore_pkt_pkg::op_e host_req_op_i;
  manycore_pkt_pkg::x_cord_t host_req_x_i;
  manycore_pkt_pkg::y_cord_t host_req_y_i;
  manycore_pkt_pkg::addr_t host_req_addr_i;
  manycore_pkt_pkg::data_t host_req_data_i;
  manycore_pkt_pkg::mask_t host_req_mask_i;
  logic host_rsp_v_o;
  logic host_rsp_ready_i;
  manycore_pkt_pkg::data_t host_rsp_data_o;
  logic host_rsp_err_o;

  // nibble fields: op, x, y, addr(2), data(8), mask, expected data(8), expected err
  logic [91:0] vec_mem [max_vecs_lp];
  int num_vecs;
  bit vecs_loaded = 1'b0;
  int data_errs;
  int flag_errs;
  int other_errs;

  manycore_pod_xbar dut_i (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.host_req_v_i(host_req_v_i)
    ,.host_req_ready_o(host_req_ready_o)
    ,.host_req_op_i(host_req_op_i)
    ,.host_req_x_i(host_req_x_i)
    ,.host_req_y_i(host_req_y_i)
    ,.host_req_addr_i(host_req_addr_i)
    ,.host_req_data_i(host_req_data_i)
    ,.host_req_mask_i(host_req_mask_i)
    ,.host_rsp_v_o(host_rsp_v_o)
    ,.host_rsp_ready_i(host_rsp_ready_i)
    ,.host_rsp_data_o(host_rsp_data_o)
    ,.host_rsp_err_o(host_rsp_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // unused entries keep an op nibble of f
  task automatic load_vectors();
    for (int i = 0; i < max_vecs_lp; i++) begin
      vec_mem[i] = {4'hf, 88'(i)};
    end
    $readmemh("manycore_testdata.txt", vec_mem);
    num_vecs = 0;
    while (num_vecs < max_vecs_lp && vec_mem[num_vecs][91:88] != 4'hf) begin
      num_vecs++;
    end
  endtask

  task automatic drive_requests();
    logic [31:0] rng;
    logic accepted;
    rng = 32'd35112;
    for (int i = 0; i < num_vecs; i++) begin
      rng = xorshift32(rng);
      host_req_v_i = 1'b0;
      repeat (rng % 3) begin
        @(posedge clk_i);
        #2;
      end
      host_req_v_i = 1'b1;
      host_req_op_i = manycore_pkt_pkg::op_e'(vec_mem[i][89:88]);
      host_req_x_i = vec_mem[i][85:84];
      host_req_y_i = vec_mem[i][81:80];
      host_req_addr_i = vec_mem[i][79:72];
      host_req_data_i = vec_mem[i][71:40];
      host_req_mask_i = vec_mem[i][39:36];
      accepted = 1'b0;
      // ready sampled mid-cycle, transfer happens at the next edge
      while (!accepted) begin
        @(negedge clk_i);
        accepted = host_req_ready_o;
        @(posedge clk_i);
        #2;
      end
    end
    host_req_v_i = 1'b0;
  endtask

  task automatic check_responses();
    logic [31:0] rng;
    logic [31:0] exp_data;
    logic exp_err;
    int idx;
    rng = xorshift32(32'd35112);
    idx = 0;
    while (idx < num_vecs) begin
      rng = xorshift32(rng);
      host_rsp_ready_i = rng[3];
      @(negedge clk_i);
      if (host_rsp_v_o && host_rsp_ready_i) begin
        exp_data = vec_mem[idx][35:4];
        exp_err = vec_mem[idx][0];
        assert (host_rsp_data_o == exp_data) else begin
          data_errs++;
          $display("ERR %0t response %0d: data %h, expected %h",
                   $time, idx, host_rsp_data_o, exp_data);
        end
        assert (host_rsp_err_o == exp_err) else begin
          flag_errs++;
          $display("ERR %0t response %0d: err %b, expected %b",
                   $time, idx, host_rsp_err_o, exp_err);
        end
        idx++;
      end
      @(posedge clk_i);
      #2;
    end
    host_rsp_ready_i = 1'b0;
  endtask

  task automatic check_no_extra();
    host_rsp_ready_i = 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      assert (!host_rsp_v_o) else begin
        other_errs++;
        $display("an extra response came back after all %0d requests were answered",
                 num_vecs);
      end
      @(posedge clk_i);
      #2;
    end
  endtask

  initial begin
    reset_i = 1'b1;
    host_req_v_i = 1'b0;
    host_req_op_i = manycore_pkt_pkg::op_load;
    host_req_x_i = '0;
    host_req_y_i = '0;
    host_req_addr_i = '0;
    host_req_data_i = '0;
    host_req_mask_i = '0;
    host_rsp_ready_i = 1'b0;
    data_errs = 0;
    flag_errs = 0;
    other_errs = 0;
    load_vectors();
    vecs_loaded = 1'b1;
    assert (num_vecs > 0) else begin
      other_errs++;
      $display("no requests could be read from manycore_testdata.txt");
    end
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    fork
      drive_requests();
      check_responses();
    join
    check_no_extra();
    $display("checks done: %0d data mismatches, %0d error flag mismatches, %0d other failures",
             data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (vecs_loaded);
    repeat (num_vecs * 40 + 200) @(posedge clk_i);
    $display("timeout: responses still missing after %0d cycles", num_vecs * 40 + 200);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* manycore_testdata.txt */
// op_x_y_addr_data_mask_expdata_experr, op 0 load 1 store 2 atomic add
// rows 0 and 3 are the north and south vcaches, rows 1 and 2 the tiles
1_0_1_10_00001000_F_00000000_0
1_1_1_10_00002000_F_00000000_0
1_0_2_10_00003000_F_00000000_0
1_1_2_10_00004000_3_00000000_0
1_0_0_10_0000A000_F_00000000_0
1_1_0_10_0000B000_F_00000000_0
1_0_3_10_0000C000_F_00000000_0
1_1_3_10_DDCCBBAA_F_00000000_0
0_0_1_10_00000000_0_00001000_0
0_1_1_10_00000000_0_00002000_0
0_0_2_10_00000000_0_00003000_0
0_1_2_10_00000000_0_00004000_0
0_0_0_10_00000000_0_0000A000_0
0_1_0_10_00000000_0_0000B000_0
0_0_3_10_00000000_0_0000C000_0
0_1_3_10_00000000_0_DDCCBBAA_0
2_0_1_10_00000005_0_00001000_0
0_0_1_10_00000000_0_00001005_0
1_1_3_10_11223344_5_00000000_0
0_1_3_10_00000000_0_DD22BB44_0
2_0_0_10_00000007_F_00000000_1
0_0_0_10_00000000_0_0000A000_0
0_1_1_50_00000000_0_00002000_0

/* files.f */
+incdir+.
manycore_pkt_pkg.sv
manycore_ctrl_pkg.sv
manycore_fwd_fifo.sv
manycore_xbar_ctrl.sv
manycore_tile_dmem.sv
manycore_vcache_bank.sv
manycore_pod_xbar.sv
manycore_pod_assertions.sv
tb_manycore_pod_xbar.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pod crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f files.f \
  --top-module tb_manycore_pod_xbar --Mdir obj_dir -o tb_manycore_pod_xbar
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_manycore_pod_xbar > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Done: errors found" "$log"; then
  exit 1
fi
exit 0
